// ==== adc_ctrl_pkg.sv ====
package adc_ctrl_pkg;

	////////////////////////////////////////
	// Command decode

	typedef enum logic [1:0] {
		CMD_NONE      = 2'd0, // No command this cycle
		CMD_SPI_WRITE = 2'd1, // Address high byte 0x31
		CMD_PHASE_SET = 2'd2  // Address high byte 0x32
	} cmd_op_t;

	localparam logic [7:0] OP_SPI_WRITE = 8'h31; // Set one SPI register
	localparam logic [7:0] OP_PHASE_SET = 8'h32; // Set encode phase target

	typedef logic [8:0] ps_value_t; // Fine phase position of the clock manager

	typedef struct packed {
		cmd_op_t   op;
		logic [6:0] reg_addr;     // SPI register address
		logic [7:0] reg_data;     // SPI register data
		ps_value_t  phase_target; // New encode phase target
	} cmd_t;

	////////////////////////////////////////
	// SPI configuration

	typedef struct packed {
		logic       rw;   // 0 is a write
		logic [6:0] addr;
		logic [7:0] data;
	} spi_word_t;

	localparam logic [7:0] INIT_WAIT = 8'd255; // Cycles before the first write

	localparam spi_word_t INIT_WORD_RESET  = 16'h0080; // Software reset
	localparam spi_word_t INIT_WORD_FORMAT = 16'h0120; // Two's complement output
	localparam spi_word_t INIT_WORD_LANES  = 16'h0200; // Two-lane output mode

	typedef enum logic [3:0] {
		SEQ_INIT_WAIT  = 4'h0, // Power-up delay
		SEQ_INIT_SEND  = 4'h1, // Wait for shifter, launch init word
		SEQ_INIT_PULSE = 4'h2, // Start strobe is out
		SEQ_IDLE       = 4'h3,
		SEQ_WR_SEND    = 4'h4, // Wait for shifter, launch command word
		SEQ_WR_PULSE   = 4'h5,
		SEQ_DRAIN      = 4'h6  // Last frame still on the wire
	} seq_state_t;

	////////////////////////////////////////
	// Encode phase stepping

	localparam ps_value_t PS_VALUE_RESET  = 9'd256;
	localparam ps_value_t PS_TARGET_RESET = 9'd380; // 256 + 124 steps
	localparam ps_value_t PS_VALUE_MAX    = 9'd511;

	typedef enum logic [3:0] {
		PS_IDLE      = 4'h0,
		PS_DECIDE    = 4'h1, // Compare value with target
		PS_STEP_EN   = 4'h2, // Raise enable with the first clock edge
		PS_STEP_REL  = 4'h3, // Drop enable and clock
		PS_STEP_WAIT = 4'h4, // Toggle clock until done
		PS_STEP_DONE = 4'h5  // Move value by one
	} ps_state_t;

	////////////////////////////////////////
	// Lane data

	typedef struct packed {
		logic [7:0]  frame;
		logic [15:0] ch1_raw;
		logic [15:0] ch0_raw;
	} lane_bus_t;

	typedef struct packed {
		logic signed [15:0] ch0;
		logic signed [15:0] ch1;
		logic [7:0]         frame;
	} adc_sample_t;

endpackage

// ==== cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode (
	input  logic               clk_in,
	input  logic               rst_in,
	input  logic               cmd_trig, // One-cycle strobe from host
	input  logic [15:0]        cmd_addr,
	input  logic [15:0]        cmd_data,
	output adc_ctrl_pkg::cmd_t cmd       // Valid one cycle after the strobe
);

	adc_ctrl_pkg::cmd_op_t op_dec;    // Opcode of the current strobe
	adc_ctrl_pkg::cmd_op_t op_q;
	logic [6:0]            reg_addr_q;
	logic [7:0]            reg_data_q;
	adc_ctrl_pkg::ps_value_t target_q;

	// High byte selects the unit
	always_comb begin
		op_dec = adc_ctrl_pkg::CMD_NONE;
		if (cmd_trig) begin
			case (cmd_addr[15:8])
				adc_ctrl_pkg::OP_SPI_WRITE: op_dec = adc_ctrl_pkg::CMD_SPI_WRITE;
				adc_ctrl_pkg::OP_PHASE_SET: op_dec = adc_ctrl_pkg::CMD_PHASE_SET;
				default:                    op_dec = adc_ctrl_pkg::CMD_NONE; // Unknown unit
			endcase
		end
	end

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			op_q <= adc_ctrl_pkg::CMD_NONE;
		end else begin
			op_q <= op_dec; // Falls back to none after one cycle
		end
	end

	// Payload fields captured on every strobe
	always_ff @(posedge clk_in) begin
		if (cmd_trig) begin
			reg_addr_q <= cmd_addr[6:0];
			reg_data_q <= cmd_data[7:0];
			target_q   <= cmd_data[8:0];
		end
	end

	assign cmd = '{op: op_q, reg_addr: reg_addr_q, reg_data: reg_data_q,
		phase_target: target_q};

endmodule

// ==== config_sequencer.sv ====
`timescale 1ns/1ps

module config_sequencer (
	input  logic                    clk_in,
	input  logic                    rst_in,
	input  adc_ctrl_pkg::cmd_t      cmd,
	input  logic                    spi_ready, // Shifter can take a word
	output logic                    spi_start, // One-cycle launch strobe
	output adc_ctrl_pkg::spi_word_t spi_word,  // Stable for the whole frame
	output logic                    seq_busy
);

	adc_ctrl_pkg::seq_state_t state;
	logic [7:0]               wait_cnt; // Power-up delay
	logic [1:0]               init_idx; // Which init word is next

	// Power-up register writes, in order
	function automatic adc_ctrl_pkg::spi_word_t init_word(input logic [1:0] idx);
		case (idx)
			2'd0:    init_word = adc_ctrl_pkg::INIT_WORD_RESET;
			2'd1:    init_word = adc_ctrl_pkg::INIT_WORD_FORMAT;
			default: init_word = adc_ctrl_pkg::INIT_WORD_LANES;
		endcase
	endfunction

	////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state     <= adc_ctrl_pkg::SEQ_INIT_WAIT;
			wait_cnt  <= adc_ctrl_pkg::INIT_WAIT;
			init_idx  <= 2'd0;
			spi_start <= 1'b0;
		end else begin
			spi_start <= 1'b0; // Strobe lasts one cycle
			case (state)
				adc_ctrl_pkg::SEQ_INIT_WAIT: begin
					wait_cnt <= wait_cnt - 8'd1;
					if (wait_cnt == 8'd1)
						state <= adc_ctrl_pkg::SEQ_INIT_SEND;
				end
				adc_ctrl_pkg::SEQ_INIT_SEND: begin
					if (spi_ready) begin
						spi_start <= 1'b1;
						state     <= adc_ctrl_pkg::SEQ_INIT_PULSE;
					end
				end
				// Ready drops on the next edge, so the next send waits on it
				adc_ctrl_pkg::SEQ_INIT_PULSE: begin
					init_idx <= init_idx + 2'd1;
					if (init_idx == 2'd2)
						state <= adc_ctrl_pkg::SEQ_DRAIN; // Lane word was the last
					else
						state <= adc_ctrl_pkg::SEQ_INIT_SEND;
				end
				adc_ctrl_pkg::SEQ_IDLE: begin
					if (cmd.op == adc_ctrl_pkg::CMD_SPI_WRITE)
						state <= adc_ctrl_pkg::SEQ_WR_SEND;
				end
				adc_ctrl_pkg::SEQ_WR_SEND: begin
					if (spi_ready) begin
						spi_start <= 1'b1;
						state     <= adc_ctrl_pkg::SEQ_WR_PULSE;
					end
				end
				adc_ctrl_pkg::SEQ_WR_PULSE: state <= adc_ctrl_pkg::SEQ_DRAIN;
				adc_ctrl_pkg::SEQ_DRAIN: begin
					if (spi_ready)
						state <= adc_ctrl_pkg::SEQ_IDLE; // Chip select is back high
				end
				default: state <= adc_ctrl_pkg::SEQ_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Word register

	// Loaded only while the shifter is ready
	always_ff @(posedge clk_in) begin
		if (state == adc_ctrl_pkg::SEQ_INIT_SEND && spi_ready) begin
			spi_word <= init_word(init_idx);
		end else if (state == adc_ctrl_pkg::SEQ_IDLE &&
			cmd.op == adc_ctrl_pkg::CMD_SPI_WRITE) begin
			spi_word.rw   <= 1'b0; // Write
			spi_word.addr <= cmd.reg_addr;
			spi_word.data <= cmd.reg_data;
		end
	end

	assign seq_busy = (state != adc_ctrl_pkg::SEQ_IDLE);

endmodule

// ==== spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter #(
	parameter logic [7:0] SPI_CLK_DIV = 8'd10 // sck half-period in clk_in cycles
) (
	input  logic                    clk_in,
	input  logic                    rst_in,
	input  logic                    spi_start, // Only honoured while ready
	input  adc_ctrl_pkg::spi_word_t spi_word,
	output logic                    spi_ready,
	output logic                    spi_scs,   // Active low chip select
	output logic                    spi_sck,   // Idles low
	output logic                    spi_sdo
);

	logic        active;    // Frame in progress
	logic [7:0]  div_cnt;   // Half-period countdown
	logic [15:0] shift_reg; // Bits still to send, MSB aligned
	logic [3:0]  bit_cnt;   // Bits already finished
	logic        launch;
	logic        half_end;  // Last cycle of a half-period

	assign launch   = !active && spi_start && spi_ready;
	assign half_end = active && (div_cnt == 8'd0);

	////////////////////////////////////////
	// Frame control

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			active    <= 1'b0;
			div_cnt   <= 8'd0;
			bit_cnt   <= 4'd0;
			spi_ready <= 1'b1;
			spi_scs   <= 1'b1;
			spi_sck   <= 1'b0;
			spi_sdo   <= 1'b0;
		end else if (!active) begin
			if (launch) begin
				active    <= 1'b1;
				spi_ready <= 1'b0;
				spi_scs   <= 1'b0;         // Select falls one cycle after start
				spi_sdo   <= spi_word[15]; // MSB first
				div_cnt   <= SPI_CLK_DIV - 8'd1;
				bit_cnt   <= 4'd0;
			end else begin
				spi_ready <= 1'b1; // One cycle after select rose
			end
		end else if (!half_end) begin
			div_cnt <= div_cnt - 8'd1;
		end else begin
			div_cnt <= SPI_CLK_DIV - 8'd1;
			if (!spi_sck) begin
				spi_sck <= 1'b1; // Slave samples here
			end else begin
				spi_sck <= 1'b0;
				if (bit_cnt == 4'd15) begin
					active  <= 1'b0;
					spi_scs <= 1'b1; // End of frame
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					spi_sdo <= shift_reg[15]; // Next bit on falling sck
				end
			end
		end
	end

	////////////////////////////////////////
	// Data path

	always_ff @(posedge clk_in) begin
		if (launch)
			shift_reg <= {spi_word[14:0], 1'b0}; // MSB already on sdo
		else if (half_end && spi_sck)
			shift_reg <= {shift_reg[14:0], 1'b0};
	end

endmodule

// ==== phase_step_ctrl.sv ====
`timescale 1ns/1ps

module phase_step_ctrl (
	input  logic               clk_in,
	input  logic               rst_in,
	input  adc_ctrl_pkg::cmd_t cmd,
	input  logic               ps_done,   // Clock manager finished a step
	input  logic               ps_locked,
	output logic               ps_clk,
	output logic               ps_en,
	output logic               ps_inc,    // 1 steps up, 0 steps down
	output logic               ps_busy
);

	adc_ctrl_pkg::ps_state_t state;
	adc_ctrl_pkg::ps_value_t ps_value;  // Current fine phase
	adc_ctrl_pkg::ps_value_t ps_target;
	logic                    step_up;
	logic                    step_down;

	// Range bounds on every step
	assign step_up   = (ps_target > ps_value) && (ps_value < adc_ctrl_pkg::PS_VALUE_MAX);
	assign step_down = (ps_target < ps_value) && (ps_value != 9'd0);

	assign ps_busy = (state != adc_ctrl_pkg::PS_IDLE);

	////////////////////////////////////////
	// Step FSM

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state     <= adc_ctrl_pkg::PS_DECIDE; // Walk to the default target
			ps_value  <= adc_ctrl_pkg::PS_VALUE_RESET;
			ps_target <= adc_ctrl_pkg::PS_TARGET_RESET;
			ps_clk    <= 1'b0;
			ps_en     <= 1'b0;
			ps_inc    <= 1'b0;
		end else begin
			case (state)
				adc_ctrl_pkg::PS_IDLE: begin
					ps_clk <= 1'b0;
					ps_en  <= 1'b0;
					if (cmd.op == adc_ctrl_pkg::CMD_PHASE_SET) begin
						ps_target <= cmd.phase_target;
						state     <= adc_ctrl_pkg::PS_DECIDE;
					end
				end
				// Hold here until the clock manager is locked
				adc_ctrl_pkg::PS_DECIDE: begin
					if (ps_locked) begin
						if (step_up) begin
							ps_inc <= 1'b1; // Direction settles before enable
							state  <= adc_ctrl_pkg::PS_STEP_EN;
						end else if (step_down) begin
							ps_inc <= 1'b0;
							state  <= adc_ctrl_pkg::PS_STEP_EN;
						end else begin
							state <= adc_ctrl_pkg::PS_IDLE; // On target or at a bound
						end
					end
				end
				adc_ctrl_pkg::PS_STEP_EN: begin
					ps_en  <= 1'b1;
					ps_clk <= 1'b1;
					state  <= adc_ctrl_pkg::PS_STEP_REL;
				end
				adc_ctrl_pkg::PS_STEP_REL: begin
					ps_en  <= 1'b0; // Enable lasts one cycle
					ps_clk <= 1'b0;
					state  <= adc_ctrl_pkg::PS_STEP_WAIT;
				end
				adc_ctrl_pkg::PS_STEP_WAIT: begin
					ps_clk <= ~ps_clk; // Keep the step clock running
					if (ps_done)
						state <= adc_ctrl_pkg::PS_STEP_DONE;
				end
				adc_ctrl_pkg::PS_STEP_DONE: begin
					ps_clk <= 1'b0;
					if (ps_inc)
						ps_value <= ps_value + 9'd1;
					else
						ps_value <= ps_value - 9'd1;
					state <= adc_ctrl_pkg::PS_DECIDE;
				end
				default: state <= adc_ctrl_pkg::PS_IDLE;
			endcase
		end
	end

endmodule

// ==== lane_reorder.sv ====
`timescale 1ns/1ps

module lane_reorder (
	input  logic                      clk_in,
	input  logic                      rst_in,
	input  adc_ctrl_pkg::lane_bus_t   lanes,  // Raw deserializer words
	output adc_ctrl_pkg::adc_sample_t sample  // One cycle later
);

	// Two lanes per channel arrive as separate bytes
	// Low byte holds the odd bits, high byte the even bits, MSB pair first
	function automatic logic [15:0] interleave(input logic [15:0] raw);
		logic [15:0] word;
		for (int k = 0; k < 8; k++) begin
			word[15 - 2*k] = raw[k];
			word[14 - 2*k] = raw[8 + k];
		end
		return word;
	endfunction

	////////////////////////////////////////
	// Output register

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			sample <= '0;
		end else begin
			sample.ch0   <= $signed(interleave(lanes.ch0_raw));
			sample.ch1   <= $signed(interleave(lanes.ch1_raw));
			sample.frame <= lanes.frame; // Frame word passes straight through
		end
	end

endmodule

// ==== ltc2195_ctrl.sv ====
`timescale 1ns/1ps

module ltc2195_ctrl #(
	parameter logic [7:0] SPI_CLK_DIV = 8'd10 // SPI half-period in clk_in cycles
) (
	input  logic                      clk_in,
	input  logic                      rst_in,
	input  logic                      cmd_trig,
	input  logic [15:0]               cmd_addr,
	input  logic [15:0]               cmd_data,
	output logic                      busy,      // Commands are dropped while high
	output logic                      spi_scs,
	output logic                      spi_sck,
	output logic                      spi_sdo,
	output logic                      ps_clk,
	output logic                      ps_en,
	output logic                      ps_inc,
	input  logic                      ps_done,
	input  logic                      ps_locked,
	input  adc_ctrl_pkg::lane_bus_t   lanes,
	output adc_ctrl_pkg::adc_sample_t sample
);

	adc_ctrl_pkg::cmd_t      cmd;
	adc_ctrl_pkg::spi_word_t spi_word;
	logic                    spi_start;
	logic                    spi_ready;
	logic                    seq_busy;
	logic                    ps_busy;

	////////////////////////////////////////
	// Command path

	cmd_decode u_cmd_decode (
		.clk_in(clk_in), .rst_in(rst_in), .cmd_trig(cmd_trig),
		.cmd_addr(cmd_addr), .cmd_data(cmd_data), .cmd(cmd)
	);

	config_sequencer u_config_sequencer (
		.clk_in(clk_in), .rst_in(rst_in), .cmd(cmd), .spi_ready(spi_ready),
		.spi_start(spi_start), .spi_word(spi_word), .seq_busy(seq_busy)
	);

	spi_shifter #(.SPI_CLK_DIV(SPI_CLK_DIV)) u_spi_shifter (
		.clk_in(clk_in), .rst_in(rst_in), .spi_start(spi_start), .spi_word(spi_word),
		.spi_ready(spi_ready), .spi_scs(spi_scs), .spi_sck(spi_sck), .spi_sdo(spi_sdo)
	);

	phase_step_ctrl u_phase_step_ctrl (
		.clk_in(clk_in), .rst_in(rst_in), .cmd(cmd), .ps_done(ps_done),
		.ps_locked(ps_locked), .ps_clk(ps_clk), .ps_en(ps_en), .ps_inc(ps_inc),
		.ps_busy(ps_busy)
	);

	////////////////////////////////////////
	// Sample path

	lane_reorder u_lane_reorder (
		.clk_in(clk_in), .rst_in(rst_in), .lanes(lanes), .sample(sample)
	);

	assign busy = seq_busy | ps_busy; // Either unit still working

endmodule

// ==== ltc2195_ctrl_assertions.sv ====
`timescale 1ns/1ps

module ltc2195_ctrl_assertions (
	input logic clk_in,
	input logic rst_in,
	input logic spi_ready,
	input logic spi_scs,
	input logic spi_sck,
	input logic ps_en
);

	// No frame while the shifter reports ready
	scs_high_when_ready: assert property (@(posedge clk_in) disable iff (rst_in)
		spi_ready |-> spi_scs) else $error("spi_scs low while spi_ready is high");

	sck_low_when_deselected: assert property (@(posedge clk_in) disable iff (rst_in)
		spi_scs |-> !spi_sck) else $error("spi_sck high while spi_scs is high");

	// Enable is a single-cycle pulse
	ps_en_single_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
		!(ps_en && $past(ps_en))) else $error("ps_en high for two cycles");

endmodule

bind spi_shifter ltc2195_ctrl_assertions u_spi_assertions (
	.clk_in(clk_in), .rst_in(rst_in), .spi_ready(spi_ready), .spi_scs(spi_scs),
	.spi_sck(spi_sck), .ps_en(1'b0)
);

bind phase_step_ctrl ltc2195_ctrl_assertions u_ps_assertions (
	.clk_in(clk_in), .rst_in(rst_in), .spi_ready(1'b0), .spi_scs(1'b1),
	.spi_sck(1'b0), .ps_en(ps_en)
);

// ==== tb_ltc2195_ctrl.sv ====
`timescale 1ns/1ps

module tb_ltc2195_ctrl;

	localparam int SPI_HALF = 4;                   // sck half-period in clk_in cycles
	localparam int FRAME_CYCLES = 32 * SPI_HALF + 8; // One SPI word plus select overhead
	localparam int WATCHDOG_CYCLES = 16 + 255 + 20 * FRAME_CYCLES + 1200 * 12 + 1000;

	logic                      clk_in = 1'b0;
	logic                      rst_in;
	logic                      cmd_trig;
	logic [15:0]               cmd_addr;
	logic [15:0]               cmd_data;
	logic                      busy;
	logic                      spi_scs, spi_sck, spi_sdo;
	logic                      ps_clk, ps_en, ps_inc;
	logic                      ps_done = 1'b0; // Driven by the clock manager model
	logic                      ps_locked;
	adc_ctrl_pkg::lane_bus_t   lanes;
	adc_ctrl_pkg::adc_sample_t sample;

	adc_ctrl_pkg::spi_word_t   spi_q[$];   // Words seen by the SPI slave
	adc_ctrl_pkg::adc_sample_t exp_q[$];   // Expected samples
	time                       due_q[$];   // Drive time of each expected sample
	int                        lane_idx;   // Next expected sample to compare
	logic [15:0]               slave_shift = '0;
	int                        slave_bits;
	adc_ctrl_pkg::ps_value_t   model_pos = adc_ctrl_pkg::PS_VALUE_RESET; // Counted position
	adc_ctrl_pkg::ps_value_t   exp_target = adc_ctrl_pkg::PS_TARGET_RESET;
	int                        up_steps, down_steps, en_pulses, ps_toggles;
	logic                      ps_stepping, ps_clk_prev, ps_en_prev;
	logic [31:0]               lfsr = 32'h3897;

	ltc2195_ctrl #(.SPI_CLK_DIV(8'(SPI_HALF))) uut (
		.clk_in(clk_in), .rst_in(rst_in), .cmd_trig(cmd_trig), .cmd_addr(cmd_addr),
		.cmd_data(cmd_data), .busy(busy), .spi_scs(spi_scs), .spi_sck(spi_sck),
		.spi_sdo(spi_sdo), .ps_clk(ps_clk), .ps_en(ps_en), .ps_inc(ps_inc),
		.ps_done(ps_done), .ps_locked(ps_locked), .lanes(lanes), .sample(sample)
	);

	always #4 clk_in = ~clk_in; // 8 ns period

	////////////////////////////////////////
	// Helpers

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	// Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	// Output bit 15-2k from raw bit k, bit 14-2k from raw bit 8+k
	function automatic adc_ctrl_pkg::adc_sample_t ref_sample(input adc_ctrl_pkg::lane_bus_t l);
		adc_ctrl_pkg::adc_sample_t s;
		s.frame = l.frame;
		for (int b = 0; b < 16; b++) begin
			if (b % 2 == 1) begin
				s.ch0[b] = l.ch0_raw[(15 - b) / 2];
				s.ch1[b] = l.ch1_raw[(15 - b) / 2];
			end else begin
				s.ch0[b] = l.ch0_raw[8 + (14 - b) / 2];
				s.ch1[b] = l.ch1_raw[8 + (14 - b) / 2];
			end
		end
		return s;
	endfunction

	// Single steps toward the target, stopping at 0 and PS_VALUE_MAX
	function automatic adc_ctrl_pkg::ps_value_t ref_phase(input adc_ctrl_pkg::ps_value_t start,
		input adc_ctrl_pkg::ps_value_t target);
		adc_ctrl_pkg::ps_value_t pos;
		pos = start;
		while (target > pos && pos != adc_ctrl_pkg::PS_VALUE_MAX)
			pos++;
		while (target < pos && pos != 9'd0)
			pos--;
		return pos;
	endfunction

	task automatic check_spi_word(input adc_ctrl_pkg::spi_word_t got,
		input adc_ctrl_pkg::spi_word_t exp);
		if (got !== exp)
			fail_now($sformatf("ERROR spi_sdo word: got 0x%h, expected 0x%h", got, exp));
	endtask

	task automatic check_sample(input adc_ctrl_pkg::adc_sample_t got,
		input adc_ctrl_pkg::adc_sample_t exp);
		if (got !== exp)
			fail_now($sformatf("ERROR sample: got 0x%h, expected 0x%h", got, exp));
	endtask

	task automatic check_phase(input adc_ctrl_pkg::ps_value_t got,
		input adc_ctrl_pkg::ps_value_t exp);
		if (got !== exp)
			fail_now($sformatf("ERROR ps_value: got 0x%h, expected 0x%h", got, exp));
	endtask

	task automatic send_cmd(input logic [15:0] addr, input logic [15:0] data);
		cmd_trig = 1'b1;
		cmd_addr = addr;
		cmd_data = data;
		@(negedge clk_in);
		cmd_trig = 1'b0; // One-cycle strobe
	endtask

	task automatic wait_idle();
		while (busy) @(negedge clk_in);
	endtask

	task automatic wait_busy_rise();
		int n;
		n = 0;
		while (!busy && n < 8) begin
			@(negedge clk_in);
			n++;
		end
		if (!busy)
			fail_now("busy never rose after a phase command");
	endtask

	////////////////////////////////////////
	// Models and compare process

	// SPI slave, samples on rising sck
	always @(posedge spi_sck or negedge spi_scs) begin
		if (!spi_scs && spi_sck) begin
			slave_shift = {slave_shift[14:0], spi_sdo};
			slave_bits++;
			if (slave_bits == 16)
				spi_q.push_back(slave_shift);
		end else begin
			slave_bits = 0; // New frame
		end
	end

	// Clock manager, done after three ps_clk toggles
	always @(negedge clk_in) begin
		ps_done = 1'b0;
		if (ps_stepping && ps_clk != ps_clk_prev)
			ps_toggles++;
		if (ps_en && !ps_en_prev) begin
			en_pulses++;
			if (model_pos == exp_target)
				fail_now("phase step issued while already on the target");
			if (ps_inc !== (exp_target > model_pos))
				fail_now("ps_inc does not match the step direction");
			if (ps_inc) begin
				if (model_pos == adc_ctrl_pkg::PS_VALUE_MAX)
					fail_now("phase step above PS_VALUE_MAX");
				model_pos++;
				up_steps++;
			end else begin
				if (model_pos == 9'd0)
					fail_now("phase step below zero");
				model_pos--;
				down_steps++;
			end
			ps_stepping = 1'b1;
			ps_toggles  = 0;
		end else if (ps_stepping && ps_toggles == 3) begin
			ps_done     = 1'b1; // One cycle
			ps_stepping = 1'b0;
		end
		ps_clk_prev = ps_clk;
		ps_en_prev  = ps_en;
	end

	// Compares each sample one cycle after its lanes were driven
	always @(negedge clk_in) begin
		if (lane_idx < exp_q.size() && due_q[lane_idx] < $time) begin
			check_sample(sample, exp_q[lane_idx]);
			lane_idx++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_in);
		fail_now("watchdog timeout, the tests did not finish");
	end

	////////////////////////////////////////
	// Stimulus

	initial begin
		adc_ctrl_pkg::spi_word_t exp_word;
		adc_ctrl_pkg::ps_value_t start_pos;
		logic [31:0]             r_addr, r_data;
		logic [7:0]              hi;
		int                      spi_rd, en_before;
		spi_rd = 0;
		rst_in = 1'b1;
		cmd_trig = 1'b0;
		cmd_addr = '0;
		cmd_data = '0;
		ps_locked = 1'b0;
		lanes = '0;
		repeat (16) @(negedge clk_in);
		rst_in = 1'b0;

		// Power-up writes while the clock manager is unlocked
		while (spi_q.size() < 3) @(negedge clk_in);
		if (en_pulses != 0)
			fail_now("ps_en pulsed while ps_locked was low");
		check_spi_word(spi_q[0], adc_ctrl_pkg::INIT_WORD_RESET);
		check_spi_word(spi_q[1], adc_ctrl_pkg::INIT_WORD_FORMAT);
		check_spi_word(spi_q[2], adc_ctrl_pkg::INIT_WORD_LANES);
		spi_rd = 3;

		// Walk from reset value to the reset target
		ps_locked = 1'b1;
		wait_idle();
		if (spi_q.size() != 3)
			fail_now("power-up sent more than the three init words before busy fell");
		if (up_steps != 124 || down_steps != 0)
			fail_now($sformatf("ERROR step counts: up 0x%h, down 0x%h, expected 0x7c, 0x0",
				up_steps, down_steps));
		check_phase(model_pos,
			ref_phase(adc_ctrl_pkg::PS_VALUE_RESET, adc_ctrl_pkg::PS_TARGET_RESET));

		for (int i = 0; i < 6; i++) begin
			rand_bits(16, r_addr);
			rand_bits(16, r_data);
			exp_word = '{rw: 1'b0, addr: r_addr[6:0], data: r_data[7:0]};
			send_cmd({adc_ctrl_pkg::OP_SPI_WRITE, r_addr[7:0]}, r_data[15:0]);
			while (spi_q.size() <= spi_rd) @(negedge clk_in);
			check_spi_word(spi_q[spi_rd], exp_word);
			spi_rd++;
			wait_idle();
		end

		// Unknown high bytes reach neither unit
		for (int i = 0; i < 3; i++) begin
			rand_bits(8, r_addr);
			rand_bits(16, r_data);
			hi = r_addr[7:0];
			if (hi == adc_ctrl_pkg::OP_SPI_WRITE || hi == adc_ctrl_pkg::OP_PHASE_SET)
				hi = hi ^ 8'h80;
			en_before = en_pulses;
			send_cmd({hi, r_data[15:8]}, r_data[15:0]);
			repeat (4) @(negedge clk_in);
			wait_idle();
			if (spi_q.size() != spi_rd || en_pulses != en_before)
				fail_now("a command with an unknown opcode started a transfer or a step");
		end

		for (int i = 0; i < 2; i++) begin
			rand_bits(9, r_data);
			start_pos  = model_pos;
			exp_target = r_data[8:0];
			send_cmd({adc_ctrl_pkg::OP_PHASE_SET, 8'h00}, {7'd0, r_data[8:0]});
			wait_busy_rise();
			wait_idle();
			check_phase(model_pos, ref_phase(start_pos, r_data[8:0]));
		end

		for (int i = 0; i < 32; i++) begin
			rand_bits(32, r_addr);
			rand_bits(8, r_data);
			lanes = {r_data[7:0], r_addr};
			exp_q.push_back(ref_sample(lanes));
			due_q.push_back($time);
			@(negedge clk_in);
		end
		while (lane_idx < exp_q.size()) @(negedge clk_in);

		if (spi_q.size() == spi_rd) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			fail_now("an SPI frame arrived that no command asked for");
		end
	end

endmodule

// ==== list.f ====
adc_ctrl_pkg.sv
cmd_decode.sv
config_sequencer.sv
spi_shifter.sv
phase_step_ctrl.sv
lane_reorder.sv
ltc2195_ctrl.sv
ltc2195_ctrl_assertions.sv
tb_ltc2195_ctrl.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the testbench with Verilator, then search the log for failure
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -f list.f --top-module tb_ltc2195_ctrl \
	> "$LOG" 2>&1 &&
	./obj_dir/Vtb_ltc2195_ctrl >> "$LOG" 2>&1 ||
	echo "FAIL: see errors above" >> "$LOG"
cat "$LOG"
! grep -q "FAIL: see errors above" "$LOG"
